/* filelist.f */
+incdir+logic
logic/rv_decode_pkg.sv
logic/decode_bus_if.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_return_stack.sv
logic/rv_decode_top.sv
testbench/rv_decode_assert.sv
testbench/rv_decode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_decode_tb
RTL_TOP   ?= rv_decode_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/rv_decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode_tb;

  import rv_decode_pkg::*;

  logic clk_i = 1'b0;
  logic rst_i, flush_i, instr_valid_i, irq_i, branch_release_i, wb_en_i;
  logic [4:0]  wb_addr_i;
  logic [31:0] instr_i, pc_i, wb_data_i;
  alu_op_t     alu_op_o;
  path_e       path_o;
  logic [2:0]  word_size_o, branch_cond_o;
  logic [4:0]  rd_addr_o;
  logic [31:0] imm_o, jal_target_o, pc_o, epc_o, rs1_data_o, rs2_data_o, ras_target_o;
  logic imm_valid_o, mem_write_o, branch_o, jal_o, jalr_o, link_o, mret_o;
  logic decoded_valid_o, ras_valid_o;

  logic [31:0] model_regs [32];
  logic [31:0] model_ras [$];
  logic [31:0] rnd, pc_r, imm_r;
  logic [4:0]  rs1_r, rs2_r, rd_r;
  logic [2:0]  f3_r;

  always #2 clk_i = ~clk_i;

  rv_decode_top rv_decode_top_i (.*);

  bind rv_decode_top rv_decode_assert assert_i (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i), .instr_valid_i(instr_valid_i),
    .irq_i(irq_i), .branch_release_i(branch_release_i), .pc_i(pc_i), .epc_i(epc_o),
    .decoded_valid_i(decoded_valid_o), .jal_i(jal_o), .jalr_i(jalr_o),
    .branch_i(branch_o), .mem_write_i(mem_write_o), .link_i(link_o), .mret_i(mret_o),
    .path_i(path_o), .push_i(dec_bus.push_ras), .link_data_i(dec_bus.link_data),
    .ras_target_i(ras_target_o), .ras_valid_i(ras_valid_o)
  );

  // Concurrent assertion failures end the run here
  always @(negedge clk_i) begin
    if (rv_decode_top_i.assert_i.fail_count != 0) begin
      $display("[ERROR] %0t concurrent assertion failed", $time);
      $display("tests failed");
      $fatal(1);
    end
  end

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // Issue one instruction and wait for its decode strobe
  task automatic issue(input logic [31:0] instr, input logic [31:0] pc);
    int n;
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    pc_i          <= pc;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!decoded_valid_o && n < 10);
    if (!decoded_valid_o) give_up("decoded valid");
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    wb_en_i   <= 1'b1;
    wb_addr_i <= addr;
    wb_data_i <= data;
    @(posedge clk_i);
    wb_en_i <= 1'b0;
    if (addr != 5'd0) model_regs[addr] = data;
  endtask

  task automatic pulse_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    model_ras.delete();
    check_eq("decoded_valid_o", 32'(decoded_valid_o), 32'd0);
    check_eq("ras_valid_o", 32'(ras_valid_o), 32'd0);
    check_eq("branch_o", 32'(branch_o), 32'd0);
  endtask

  function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    logic [31:0] low;
    low = (v << (32 - bits)) >> (32 - bits);
    return low | (v[bits-1] ? ~(32'hffff_ffff >> (32 - bits)) : 32'd0);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  // Both read ports on x0 after the ignored write
  task automatic read_x0();
    issue({7'h00, 5'd0, 5'd0, 3'b000, 5'd2, OP, 2'b11}, 32'h104);
    check_eq("rs1_data_o x0", rs1_data_o, 32'd0);
    check_eq("rs2_data_o x0", rs2_data_o, 32'd0);
  endtask

  task automatic run_r_type();
    logic [6:0] f7;
    rnd = $urandom();
    f7 = (rnd[1:0] == 2'd0) ? 7'h20 : (rnd[1:0] == 2'd1) ? 7'h01 : 7'h00;
    rs1_r = rnd[6:2];
    rs2_r = rnd[11:7];
    rd_r  = rnd[16:12];
    f3_r  = rnd[19:17];
    issue({f7, rs2_r, rs1_r, f3_r, rd_r, OP, 2'b11}, 32'h100);
    check_eq("alu_op_o", 32'(alu_op_o), 32'({f7[5], f3_r}));
    check_eq("path_o", 32'(path_o), 32'(f7[0] ? PATH_MUL : PATH_ALU));
    check_eq("rs1_data_o", rs1_data_o, (rs1_r == 5'd0) ? 32'd0 : model_regs[rs1_r]);
    check_eq("rs2_data_o", rs2_data_o, (rs2_r == 5'd0) ? 32'd0 : model_regs[rs2_r]);
    check_eq("rd_addr_o", 32'(rd_addr_o), 32'(rd_r));
  endtask

  task automatic run_imm_type();
    rnd = $urandom();
    imm_r = $urandom();
    pc_r = {$urandom() & 32'h00ff_fffc};
    rs1_r = rnd[4:0];
    rs2_r = rnd[9:5];
    rd_r  = rnd[14:10];
    f3_r  = rnd[17:15];
    case (rnd[20:18] % 5)
      0: begin
        issue(enc_i(imm_r[11:0], rs1_r, {1'b0, f3_r[1:0]}, rd_r, LOAD), pc_r);
        check_eq("imm_o load", imm_o, sext({20'd0, imm_r[11:0]}, 12));
        check_eq("path_o load", 32'(path_o), 32'(PATH_MEM));
        check_eq("mem_write_o load", 32'(mem_write_o), 32'd0);
        check_eq("word_size_o load", 32'(word_size_o), 32'({1'b0, f3_r[1:0]}));
      end
      1: begin
        issue({imm_r[11:5], rs2_r, rs1_r, {1'b0, f3_r[1:0]}, imm_r[4:0], STORE, 2'b11}, pc_r);
        check_eq("imm_o store", imm_o, sext({20'd0, imm_r[11:0]}, 12));
        check_eq("path_o store", 32'(path_o), 32'(PATH_MEM));
        check_eq("mem_write_o store", 32'(mem_write_o), 32'd1);
        check_eq("rs2_data_o store", rs2_data_o, (rs2_r == 5'd0) ? 32'd0 : model_regs[rs2_r]);
        check_eq("word_size_o store", 32'(word_size_o), 32'({1'b0, f3_r[1:0]}));
      end
      2: begin
        issue(enc_i(imm_r[11:0], rs1_r, 3'b000, rd_r, OP_IMM), pc_r);
        check_eq("imm_o addi", imm_o, sext({20'd0, imm_r[11:0]}, 12));
        check_eq("path_o addi", 32'(path_o), 32'(PATH_ALU));
        check_eq("mem_write_o addi", 32'(mem_write_o), 32'd0);
      end
      3: begin
        issue({imm_r[19:0], rd_r, LUI, 2'b11}, pc_r);
        check_eq("imm_o lui", imm_o, {imm_r[19:0], 12'd0});
        check_eq("mem_write_o lui", 32'(mem_write_o), 32'd0);
      end
      default: begin
        issue({imm_r[19:0], rd_r, AUIPC, 2'b11}, pc_r);
        check_eq("imm_o auipc", imm_o, {imm_r[19:0], 12'd0} + pc_r);
        check_eq("path_o auipc", 32'(path_o), 32'(PATH_ALU));
      end
    endcase
    check_eq("imm_valid_o", 32'(imm_valid_o), 32'd1);
    check_eq("pc_o", pc_o, pc_r);
  endtask

  task automatic run_call_return();
    logic [20:0] off;
    off = 21'h0_0840; // Forward jump of 0x840
    pulse_flush();
    issue({off[20], off[10:1], off[11], off[19:12], 5'd1, JAL, 2'b11}, 32'h2000);
    check_eq("jal_o", 32'(jal_o), 32'd1);
    check_eq("jal_target_o", jal_target_o, 32'h2000 + 32'h840);
    check_eq("link_o", 32'(link_o), 32'd1);
    model_ras.push_back(32'h2004);
    @(negedge clk_i);
    check_eq("ras_target_o", ras_target_o, model_ras[$]);
    check_eq("ras_valid_o push", 32'(ras_valid_o), 32'd1);
    issue(enc_i(12'd0, 5'd1, 3'b000, 5'd0, JALR), 32'h2840);
    check_eq("jalr_o", 32'(jalr_o), 32'd1);
    void'(model_ras.pop_back());
    @(negedge clk_i);
    check_eq("ras_valid_o pop", 32'(ras_valid_o), 32'(model_ras.size() != 0));
  endtask

  task automatic run_branch();
    int n;
    logic [12:0] off;
    off = 13'h1ff0; // Backward branch
    issue({off[12], off[10:5], 5'd3, 5'd4, 3'b101, off[4:1], off[11], BRANCH, 2'b11}, 32'h3000);
    check_eq("branch_o", 32'(branch_o), 32'd1);
    check_eq("branch_cond_o", 32'(branch_cond_o), 32'd5);
    check_eq("imm_o branch", imm_o, 32'hffff_fff0);
    repeat (3) begin
      @(negedge clk_i);
      check_eq("branch_o held", 32'(branch_o), 32'd1);
    end
    @(posedge clk_i);
    branch_release_i <= 1'b1;
    @(posedge clk_i);
    branch_release_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (branch_o && n < 10);
    if (branch_o) give_up("branch release");
  endtask

  task automatic run_irq();
    @(posedge clk_i);
    irq_i <= 1'b1;
    pc_i  <= 32'h0000_4abc;
    @(posedge clk_i);
    irq_i <= 1'b0;
    pc_i  <= 32'h0000_5000;
    repeat (2) @(negedge clk_i);
    check_eq("epc_o", epc_o, 32'h0000_4abc);
  endtask

  task automatic decode_mret();
    issue(32'h3020_0073, 32'h4000); // MRET
    check_eq("mret_o", 32'(mret_o), 32'd1);
    issue(32'h0000_0013, 32'h4004); // NOP
    check_eq("mret_o nop", 32'(mret_o), 32'd0);
  endtask

  // Stack entry and held branch for the final flush to clear
  task automatic load_stack_and_branch();
    issue({20'd0, 5'd5, JAL, 2'b11}, 32'h5000); // JAL t0
    model_ras.push_back(32'h5004);
    issue({7'd0, 5'd0, 5'd0, 3'b000, 5'd0, BRANCH, 2'b11}, 32'h5008);
    check_eq("ras_target_o t0", ras_target_o, model_ras[$]);
    check_eq("ras_valid_o t0", 32'(ras_valid_o), 32'd1);
    check_eq("branch_o before flush", 32'(branch_o), 32'd1);
  endtask

  initial begin
    void'($urandom(32'h2eff0814));
    rst_i            <= 1'b1;
    flush_i          <= 1'b0;
    instr_valid_i    <= 1'b0;
    instr_i          <= 32'h0000_0013;
    pc_i             <= 32'd0;
    irq_i            <= 1'b0;
    branch_release_i <= 1'b0;
    wb_en_i          <= 1'b0;
    wb_addr_i        <= 5'd0;
    wb_data_i        <= 32'd0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_eq("decoded_valid_o reset", 32'(decoded_valid_o), 32'd0);
    check_eq("ras_valid_o reset", 32'(ras_valid_o), 32'd0);
    check_eq("mem_write_o reset", 32'(mem_write_o), 32'd0);
    for (int r = 0; r < 32; r++) write_reg(5'(r), $urandom()); // Fill every register
    write_reg(5'd0, 32'hdead_beef); // Ignored by x0
    pulse_flush();
    read_x0();
    repeat (30) run_r_type();
    repeat (40) run_imm_type();
    run_call_return();
    run_branch();
    run_irq();
    decode_mret();
    load_stack_and_branch();
    pulse_flush();
    repeat (3) @(posedge clk_i);
    if (rv_decode_top_i.assert_i.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/rv_decode_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode_assert (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                flush_i,
  input  logic                instr_valid_i,
  input  logic                irq_i,
  input  logic                branch_release_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic [`RV_XLEN-1:0] epc_i,
  input  logic                decoded_valid_i,
  input  logic                jal_i,
  input  logic                jalr_i,
  input  logic                branch_i,
  input  logic                mem_write_i,
  input  logic                link_i,
  input  logic                mret_i,
  input  logic [2:0]          path_i,
  input  logic                push_i,
  input  logic [`RV_XLEN-1:0] link_data_i,
  input  logic [`RV_XLEN-1:0] ras_target_i,
  input  logic                ras_valid_i
);

  import rv_decode_pkg::*;

  int unsigned fail_count = 0; // Watched by the testbench

  // Control outputs inactive after reset or flush
  clear_ctrl: assert property (@(posedge clk_i) (rst_i || flush_i) |=>
      !decoded_valid_i && !jal_i && !jalr_i && !branch_i && !mem_write_i &&
      !link_i && !mret_i && !ras_valid_i)
    else begin $error("control outputs not cleared"); fail_count++; end

  valid_follows: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
      instr_valid_i |=> decoded_valid_i)
    else begin $error("decoded valid missing"); fail_count++; end

  valid_drops: assert property (@(posedge clk_i) !instr_valid_i |=> !decoded_valid_i)
    else begin $error("decoded valid without instruction"); fail_count++; end

  store_path: assert property (@(posedge clk_i)
      (decoded_valid_i && mem_write_i) |-> (path_i == PATH_MEM))
    else begin $error("store not on memory path"); fail_count++; end

  epc_capture: assert property (@(posedge clk_i) irq_i |=> (epc_i == $past(pc_i)))
    else begin $error("exception PC not captured"); fail_count++; end

  // Pushed link address becomes the top entry
  ras_push: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
      (decoded_valid_i && push_i) |=> (ras_valid_i && ras_target_i == $past(link_data_i)))
    else begin $error("return stack top wrong after push"); fail_count++; end

  branch_hold: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
      (branch_i && !instr_valid_i && !branch_release_i && !flush_i) |=> branch_i)
    else begin $error("branch flag dropped without release"); fail_count++; end

endmodule

`default_nettype wire

/* logic/rv_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  logic                     instr_valid_i,
  input  logic [`RV_XLEN-1:0]      instr_i,
  input  logic [`RV_XLEN-1:0]      pc_i,
  input  logic                     irq_i,
  input  logic                     branch_release_i,
  input  logic                     wb_en_i,
  input  logic [`RV_REG_BITS-1:0]  wb_addr_i,
  input  logic [`RV_XLEN-1:0]      wb_data_i,
  output rv_decode_pkg::alu_op_t   alu_op_o,
  output rv_decode_pkg::path_e     path_o,
  output logic [2:0]               word_size_o,
  output logic [`RV_REG_BITS-1:0]  rd_addr_o,
  output logic [`RV_XLEN-1:0]      imm_o,
  output logic                     imm_valid_o,
  output logic                     mem_write_o,
  output logic                     branch_o,
  output logic [2:0]               branch_cond_o,
  output logic                     jal_o,
  output logic [`RV_XLEN-1:0]      jal_target_o,
  output logic                     jalr_o,
  output logic                     link_o,
  output logic                     mret_o,
  output logic [`RV_XLEN-1:0]      pc_o,
  output logic [`RV_XLEN-1:0]      epc_o,
  output logic                     decoded_valid_o,
  output logic [`RV_XLEN-1:0]      rs1_data_o,
  output logic [`RV_XLEN-1:0]      rs2_data_o,
  output logic [`RV_XLEN-1:0]      ras_target_o,
  output logic                     ras_valid_o
);

  decode_bus_if #(.XLEN(`RV_XLEN), .REG_BITS(`RV_REG_BITS)) dec_bus ();

  rv_decode decode_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .pc_i             (pc_i),
    .irq_i            (irq_i),
    .branch_release_i (branch_release_i),
    .alu_op_o         (alu_op_o),
    .path_o           (path_o),
    .word_size_o      (word_size_o),
    .rd_addr_o        (rd_addr_o),
    .imm_o            (imm_o),
    .imm_valid_o      (imm_valid_o),
    .mem_write_o      (mem_write_o),
    .branch_o         (branch_o),
    .branch_cond_o    (branch_cond_o),
    .jal_o            (jal_o),
    .jal_target_o     (jal_target_o),
    .jalr_o           (jalr_o),
    .link_o           (link_o),
    .mret_o           (mret_o),
    .pc_o             (pc_o),
    .epc_o            (epc_o),
    .decoded_valid_o  (decoded_valid_o),
    .bus              (dec_bus.producer)
  );

  // Reads use the addresses decode registered this cycle
  rv_regfile regfile_i (
    .clk_i      (clk_i),
    .wb_en_i    (wb_en_i),
    .wb_addr_i  (wb_addr_i),
    .wb_data_i  (wb_data_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o),
    .bus        (dec_bus.reg_reader)
  );

  rv_return_stack #(.DEPTH(`RV_RAS_DEPTH)) ras_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .ras_target_o (ras_target_o),
    .ras_valid_o  (ras_valid_o),
    .bus          (dec_bus.stack_user)
  );

endmodule

`default_nettype wire

/* logic/rv_return_stack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_return_stack #(
  parameter int DEPTH = `RV_RAS_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                flush_i,
  output logic [`RV_XLEN-1:0] ras_target_o,
  output logic                ras_valid_o,
  decode_bus_if.stack_user    bus
);

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [`RV_XLEN-1:0] entries [DEPTH];
  logic [PTR_BITS-1:0] top_q;
  logic [CNT_BITS-1:0] count_q;
  logic                do_push, do_pop;

  // Hints only count on a decode strobe
  assign do_push = bus.valid & bus.push_ras;
  assign do_pop  = bus.valid & bus.pop_ras;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (do_push && do_pop) begin
      if (count_q == '0)
        count_q <= CNT_BITS'(1); // Replace on empty leaves one entry
    end else if (do_push) begin
      top_q <= top_q + 1'b1; // Wraps onto the oldest entry when full
      if (count_q != CNT_BITS'(DEPTH))
        count_q <= count_q + 1'b1;
    end else if (do_pop && (count_q != '0)) begin
      top_q   <= top_q - 1'b1;
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && do_pop)
      entries[top_q] <= bus.link_data;
    else if (do_push)
      entries[top_q + 1'b1] <= bus.link_data;
  end

  assign ras_target_o = entries[top_q];
  assign ras_valid_o  = (count_q != '0);

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_regfile (
  input  logic                    clk_i,
  input  logic                    wb_en_i,
  input  logic [`RV_REG_BITS-1:0] wb_addr_i,
  input  logic [`RV_XLEN-1:0]     wb_data_i,
  output logic [`RV_XLEN-1:0]     rs1_data_o,
  output logic [`RV_XLEN-1:0]     rs2_data_o,
  decode_bus_if.reg_reader        bus
);

  logic [`RV_XLEN-1:0] regs [1:(1 << `RV_REG_BITS) - 1]; // No storage for x0

  always_ff @(posedge clk_i) begin
    if (wb_en_i && (wb_addr_i != '0))
      regs[wb_addr_i] <= wb_data_i;
  end

  // x0 first, then same-cycle write forwarding
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_BITS-1:0] addr);
    logic [`RV_XLEN-1:0] data;
    if (addr == '0)
      data = '0;
    else if (wb_en_i && (wb_addr_i == addr))
      data = wb_data_i;
    else
      data = regs[addr];
    return data;
  endfunction

  always_comb begin
    rs1_data_o = read_port(bus.rs1_addr);
    rs2_data_o = read_port(bus.rs2_addr);
  end

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  logic                     instr_valid_i,
  input  logic [`RV_XLEN-1:0]      instr_i,
  input  logic [`RV_XLEN-1:0]      pc_i,
  input  logic                     irq_i,
  input  logic                     branch_release_i,
  output rv_decode_pkg::alu_op_t   alu_op_o,
  output rv_decode_pkg::path_e     path_o,
  output logic [2:0]               word_size_o,
  output logic [`RV_REG_BITS-1:0]  rd_addr_o,
  output logic [`RV_XLEN-1:0]      imm_o,
  output logic                     imm_valid_o,
  output logic                     mem_write_o,
  output logic                     branch_o,
  output logic [2:0]               branch_cond_o,
  output logic                     jal_o,
  output logic [`RV_XLEN-1:0]      jal_target_o,
  output logic                     jalr_o,
  output logic                     link_o,
  output logic                     mret_o,
  output logic [`RV_XLEN-1:0]      pc_o,
  output logic [`RV_XLEN-1:0]      epc_o,
  output logic                     decoded_valid_o,
  decode_bus_if.producer           bus
);

  import rv_decode_pkg::*;

  localparam int XLEN = `RV_XLEN;

  // Instruction formats, one-hot
  localparam logic [5:0] FMT_R = 6'b000001;
  localparam logic [5:0] FMT_I = 6'b000010;
  localparam logic [5:0] FMT_S = 6'b000100;
  localparam logic [5:0] FMT_U = 6'b001000;
  localparam logic [5:0] FMT_B = 6'b010000;
  localparam logic [5:0] FMT_J = 6'b100000;

  localparam logic [31:0] MRET_WORD = 32'h3020_0073;

  opcode_e                 opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [`RV_REG_BITS-1:0] rd;
  logic [`RV_REG_BITS-1:0] rs1;
  logic [`RV_REG_BITS-1:0] rs2;
  logic [5:0]              fmt;
  logic [XLEN-1:0]         imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0]         imm_next;
  alu_op_t                 alu_op_next;
  path_e                   path_next;
  logic                    is_jal, is_jalr, rd_link, rs1_link;
  logic                    push_next, pop_next;

  logic [`RV_REG_BITS-1:0] rs1_q, rs2_q;
  logic                    push_q, pop_q;
  logic [XLEN-1:0]         link_q;

  assign opcode = opcode_e'(instr_i[6:2]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  // Sign-extended immediates per format
  assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    case (opcode)
      LOAD, OP_IMM, JALR, SYSTEM: fmt = FMT_I;
      AUIPC, LUI:                 fmt = FMT_U;
      STORE:                      fmt = FMT_S;
      OP:                         fmt = FMT_R;
      BRANCH:                     fmt = FMT_B;
      JAL:                        fmt = FMT_J;
      default:                    fmt = 6'b0; // FENCE and unknown
    endcase
  end

  always_comb begin
    case (fmt)
      FMT_I:   imm_next = imm_i;
      FMT_S:   imm_next = imm_s;
      FMT_B:   imm_next = imm_b;
      FMT_J:   imm_next = imm_j;
      FMT_U:   imm_next = (opcode == AUIPC) ? imm_u + pc_i : imm_u;
      default: imm_next = '0;
    endcase
  end

  always_comb begin
    alu_op_next = '0; // Plain add for address and upper-immediate forms
    if (opcode == OP)
      alu_op_next = {funct7[5], funct3};
    else if (opcode == OP_IMM)
      alu_op_next = {funct7[5] & (funct3 == 3'b101), funct3}; // SRAI only
  end

  always_comb begin
    if (opcode == LOAD || opcode == STORE)
      path_next = PATH_MEM;
    else if (opcode == OP && funct7[0])
      path_next = PATH_MUL;
    else
      path_next = PATH_ALU;
  end

  // Return stack hints from link register use
  assign is_jal    = (opcode == JAL);
  assign is_jalr   = (opcode == JALR);
  assign rd_link   = (rd == LINK_REG) || (rd == LINK_REG_ALT);
  assign rs1_link  = (rs1 == LINK_REG) || (rs1 == LINK_REG_ALT);
  assign push_next = rd_link & (is_jal | is_jalr);
  assign pop_next  = rs1_link & is_jalr & (~rd_link | (rd == rs1));

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      decoded_valid_o <= 1'b0;
      imm_valid_o     <= 1'b0;
      jal_o           <= 1'b0;
      jalr_o          <= 1'b0;
      branch_o        <= 1'b0;
      branch_cond_o   <= 3'b0;
      mem_write_o     <= 1'b0;
      link_o          <= 1'b0;
      mret_o          <= 1'b0;
      push_q          <= 1'b0;
      pop_q           <= 1'b0;
    end else begin
      decoded_valid_o <= instr_valid_i;
      if (instr_valid_i) begin
        pc_o          <= pc_i;
        alu_op_o      <= alu_op_next;
        path_o        <= path_next;
        imm_o         <= imm_next;
        imm_valid_o   <= |(fmt & (FMT_I | FMT_S | FMT_U | FMT_J));
        rs1_q         <= |(fmt & (FMT_R | FMT_I | FMT_S | FMT_B)) ? rs1 : '0;
        rs2_q         <= |(fmt & (FMT_R | FMT_S | FMT_B)) ? rs2 : '0;
        rd_addr_o     <= |(fmt & (FMT_R | FMT_I | FMT_U | FMT_J)) ? rd : '0;
        mem_write_o   <= (opcode == STORE);
        branch_o      <= (fmt == FMT_B);
        branch_cond_o <= (fmt == FMT_B) ? funct3 : 3'b0;
        jal_o         <= is_jal;
        jalr_o        <= is_jalr;
        link_o        <= is_jal | is_jalr;
        mret_o        <= (instr_i == MRET_WORD);
        push_q        <= push_next;
        pop_q         <= pop_next;
        if (opcode == LOAD || opcode == STORE)
          word_size_o <= funct3;
        if (is_jal)
          jal_target_o <= pc_i + imm_j;
        if (is_jal || is_jalr)
          link_q <= pc_i + 32'd4; // Return address
      end else if (branch_release_i) begin
        branch_o <= 1'b0; // Stall released while idle
      end
    end
  end

  // Exception PC
  always_ff @(posedge clk_i) begin
    if (irq_i)
      epc_o <= pc_i;
  end

  assign bus.valid     = decoded_valid_o;
  assign bus.rs1_addr  = rs1_q;
  assign bus.rs2_addr  = rs2_q;
  assign bus.rd_addr   = rd_addr_o;
  assign bus.push_ras  = push_q;
  assign bus.pop_ras   = pop_q;
  assign bus.link_data = link_q;

endmodule

`default_nettype wire

/* logic/decode_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

interface decode_bus_if #(
  parameter int XLEN     = `RV_XLEN,
  parameter int REG_BITS = `RV_REG_BITS
);

  logic                valid;     // One cycle per decoded instruction
  logic [REG_BITS-1:0] rs1_addr;
  logic [REG_BITS-1:0] rs2_addr;
  logic [REG_BITS-1:0] rd_addr;
  logic                push_ras;
  logic                pop_ras;
  logic [XLEN-1:0]     link_data; // Return address for a push

  modport producer (
    output valid,
    output rs1_addr,
    output rs2_addr,
    output rd_addr,
    output push_ras,
    output pop_ras,
    output link_data
  );

  modport reg_reader (
    input rs1_addr,
    input rs2_addr
  );

  modport stack_user (
    input valid,
    input push_ras,
    input pop_ras,
    input link_data
  );

endinterface

`default_nettype wire

/* logic/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

  // Major opcodes, instruction bits [6:2]
  typedef enum logic [4:0] {
    LOAD   = 5'b00000,
    OP_IMM = 5'b00100,
    AUIPC  = 5'b00101,
    STORE  = 5'b01000,
    OP     = 5'b01100,
    LUI    = 5'b01101,
    BRANCH = 5'b11000,
    JALR   = 5'b11001,
    JAL    = 5'b11011,
    SYSTEM = 5'b11100
  } opcode_e;

  // Result path, one-hot
  typedef enum logic [2:0] {
    PATH_ALU = 3'b001,
    PATH_MEM = 3'b010,
    PATH_MUL = 3'b100
  } path_e;

  // Alternate bit selects SUB or SRA/SRAI
  typedef struct packed {
    logic       alt;
    logic [2:0] funct3;
  } alu_op_t;

  // ra and t0, the two link registers
  localparam logic [4:0] LINK_REG     = 5'd1;
  localparam logic [4:0] LINK_REG_ALT = 5'd5;

endpackage

`default_nettype wire

/* logic/rv_decode_params.svh */
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Data and address width
`define RV_XLEN 32

// Register address width
`define RV_REG_BITS 5

// Return stack entries, power of two
`define RV_RAS_DEPTH 4

`endif
